// File: verilog.f
+incdir+verif
hw/fpmul_pkg.sv
hw/fpmul_operand_prep.sv
hw/fpmul_significand_mult.sv
hw/fpmul_normalize.sv
hw/fpmul_top.sv
verif/fpmul_tb.sv

// File: Bender.yml
package:
  name: fpmul

sources:
  - hw/fpmul_pkg.sv
  - hw/fpmul_operand_prep.sv
  - hw/fpmul_significand_mult.sv
  - hw/fpmul_normalize.sv
  - hw/fpmul_top.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/fpmul_tb.sv

// File: verif/fpmul_vectors.svh
// ################################################
// Directed stimulus for the multiply pipeline
// testbench, one entry per cycle, applied in order
// Included inside the testbench module body
// ################################################

// Columns are valid, opcode, operand a, operand b and expected result
typedef struct packed {
	logic valid;
	fp_op_e op;
	fp_word_t operand_a;
	fp_word_t operand_b;
	fp_word_t expected;
} vector_t;

localparam int VEC_COUNT = 20;

vector_t vec_table [VEC_COUNT];

// Idle entries carry junk operands that must not produce a result
task automatic load_vector_table();
	// Exact products of 1.5*2.0 then -2.0*0.5 then 3.0*3.0
	vec_table[0] = {1'b1, FP_OP_FMUL, 32'h3FC0_0000, 32'h4000_0000, 32'h4040_0000};
	vec_table[1] = {1'b1, FP_OP_FMUL, 32'hC000_0000, 32'h3F00_0000, 32'hBF80_0000};
	vec_table[2] = {1'b1, FP_OP_FMUL, 32'h4040_0000, 32'h4040_0000, 32'h4110_0000};
	vec_table[3] = {1'b0, FP_OP_FMUL, 32'h4040_0000, 32'h4040_0000, 32'h0000_0000};
	// 1.1*1.1 and a 1.75 case where rounding to nearest would bump the last bit
	vec_table[4] = {1'b1, FP_OP_FMUL, 32'h3F8C_CCCD, 32'h3F8C_CCCD, 32'h3F9A_E148};
	vec_table[5] = {1'b1, FP_OP_FMUL, 32'h3FE0_0000, 32'h3F80_0001, 32'h3FE0_0001};
	vec_table[6] = {1'b0, FP_OP_ITOF, 32'h1234_5678, 32'h0000_0005, 32'h0000_0000};
	vec_table[7] = {1'b0, FP_OP_FMUL, 32'h3F80_0000, 32'h3F80_0000, 32'h0000_0000};
	// Zero on either side, -0.0 included, and a negative times zero
	vec_table[8] = {1'b1, FP_OP_FMUL, 32'h0000_0000, 32'h4040_0000, 32'h0000_0000};
	vec_table[9] = {1'b1, FP_OP_FMUL, 32'h4040_0000, 32'h8000_0000, 32'h0000_0000};
	vec_table[10] = {1'b1, FP_OP_FMUL, 32'hC000_0000, 32'h0000_0000, 32'h0000_0000};
	// ITOF ignores operand a, so some entries put garbage there
	vec_table[11] = {1'b1, FP_OP_ITOF, 32'h1234_5678, 32'h0000_0000, 32'h0000_0000};
	vec_table[12] = {1'b1, FP_OP_ITOF, 32'h0000_0000, 32'h0000_0001, 32'h3F80_0000};
	vec_table[13] = {1'b1, FP_OP_ITOF, 32'h0000_0000, 32'hFFFF_FFFF, 32'hBF80_0000};
	vec_table[14] = {1'b0, FP_OP_ITOF, 32'h0000_0000, 32'h0000_0009, 32'h0000_0000};
	vec_table[15] = {1'b1, FP_OP_ITOF, 32'h0000_0000, 32'h0000_0007, 32'h40E0_0000};
	vec_table[16] = {1'b1, FP_OP_ITOF, 32'h1234_5678, 32'h0000_03E8, 32'h447A_0000};
	vec_table[17] = {1'b1, FP_OP_ITOF, 32'h0000_0000, 32'hFFFE_1DC0, 32'hC7F1_2000};
	// Largest integer truncates to all ones in the fraction
	vec_table[18] = {1'b1, FP_OP_ITOF, 32'h0000_0000, 32'h7FFF_FFFF, 32'h4EFF_FFFF};
	vec_table[19] = {1'b1, FP_OP_ITOF, 32'h0000_0000, 32'h8000_0000, 32'hCF00_0000};
endtask

// File: verif/fpmul_tb.sv
// ################################################
// Testbench for the floating-point multiply pipeline
// Applies the directed table and a random FMUL run,
// checks every result and its 3-cycle latency
// ################################################

`timescale 1ns/1ns

module fpmul_tb;

	import fpmul_pkg::*;

	localparam int RESET_CYCLES = 8;
	localparam int IDLE_CYCLES = 3;
	localparam int LATENCY = 3;
	localparam int RAND_COUNT = 12;
	localparam logic [31:0] LFSR_SEED = 32'h9558_0c30;
	localparam logic [31:0] LFSR_TAPS = 32'hD000_0001;

	`include "fpmul_vectors.svh"

	// Everything the run drives plus slack for the pipeline to drain
	localparam int TIMEOUT_CYCLES = RESET_CYCLES + IDLE_CYCLES + VEC_COUNT + RAND_COUNT + 20;

	// A result still owed by the DUT and the cycle it is due in
	typedef struct packed {
		logic [31:0] due;
		fp_word_t expected;
	} pending_t;

	// Starting low before any process runs keeps time 0 free of a falling edge
	logic clk = 1'b0;
	logic rst_n_i;
	logic valid_i;
	fp_op_e op_i;
	fp_word_t operand_a_i;
	fp_word_t operand_b_i;
	logic valid_o;
	fp_word_t result_o;

	pending_t pending_q[$];
	logic [31:0] lfsr_state;
	int cycle_count = 0;
	int value_errors = 0;
	int valid_errors = 0;
	int result_checks = 0;

	fpmul_top uut (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.valid_i(valid_i),
		.op_i(op_i),
		.operand_a_i(operand_a_i),
		.operand_b_i(operand_b_i),
		.valid_o(valid_o),
		.result_o(result_o)
	);

	always #20 clk = ~clk;

	// Counts rising edges, so a drive after edge c is due at c + LATENCY
	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
	end

	task automatic check_result(input fp_word_t expected, input fp_word_t actual);
		result_checks++;
		if (actual !== expected)
		begin
			value_errors++;
			$display("** Error: result_o expected %h, got %h at cycle %0d",
				expected, actual, cycle_count);
		end
	endtask

	task automatic check_valid(input logic expected, input logic actual);
		if (actual !== expected)
		begin
			valid_errors++;
			$display("** Error: valid_o expected %h, got %h at cycle %0d",
				expected, actual, cycle_count);
		end
	endtask

	task automatic report_counts();
		$display("Checked %0d results with %0d value errors and %0d valid errors",
			result_checks, value_errors, valid_errors);
	endtask

	// Galois step that shifts right and folds the taps in on a one
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		if (state[0])
		begin
			return (state >> 1) ^ LFSR_TAPS;
		end
		return state >> 1;
	endfunction

	task automatic take_bits(input int count, output logic [31:0] bits);
		bits = '0;
		for (int i = 0; i < count; i++)
		begin
			bits = {bits[30:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	// Exponents stay within 100 to 150 so every product is a normal number
	task automatic random_operand(output fp_word_t operand);
		logic [31:0] sign_bits;
		logic [31:0] exp_bits;
		logic [31:0] frac_bits;
		take_bits(1, sign_bits);
		take_bits(6, exp_bits);
		take_bits(23, frac_bits);
		operand.sign = sign_bits[0];
		operand.exponent = 8'(100 + (exp_bits % 51));
		operand.fraction = frac_bits[22:0];
	endtask

	// Reference multiply of two normal numbers with truncation toward zero
	function automatic fp_word_t fmul_model(input fp_word_t a, input fp_word_t b);
		logic [47:0] product;
		int exp_sum;
		fp_word_t result;
		product = {24'd0, 1'b1, a.fraction} * {24'd0, 1'b1, b.fraction};
		exp_sum = int'(a.exponent) + int'(b.exponent) - FP_BIAS;
		result.sign = a.sign ^ b.sign;
		if (product[47])
		begin
			result.exponent = 8'(exp_sum + 1);
			result.fraction = product[46:24];
		end
		else
		begin
			result.exponent = 8'(exp_sum);
			result.fraction = product[45:23];
		end
		return result;
	endfunction

	task automatic drive_operation(input logic valid, input fp_op_e op,
		input fp_word_t a, input fp_word_t b, input fp_word_t expected);
		pending_t entry;
		@(posedge clk);
		#2;
		valid_i = valid;
		op_i = op;
		operand_a_i = a;
		operand_b_i = b;
		if (valid)
		begin
			entry.due = 32'(cycle_count + LATENCY);
			entry.expected = expected;
			pending_q.push_back(entry);
		end
	endtask

	// Outputs are settled at the falling edge, away from the register updates
	always @(negedge clk)
	begin : monitor_outputs
		logic due_now;
		due_now = (pending_q.size() != 0) && (pending_q[0].due == 32'(cycle_count));
		check_valid(due_now, valid_o);
		if (due_now)
		begin
			if (valid_o)
			begin
				check_result(pending_q[0].expected, result_o);
			end
			pending_q.delete(0);
		end
	end

	always @(posedge clk)
	begin
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("Timeout after %0d cycles with %0d results still pending",
				cycle_count, pending_q.size());
			report_counts();
			$display("Simulation failed");
			$finish;
		end
	end

	initial
	begin : run_tests
		fp_word_t rand_a;
		fp_word_t rand_b;
		rst_n_i = 1'b0;
		valid_i = 1'b0;
		op_i = FP_OP_FMUL;
		operand_a_i = '0;
		operand_b_i = '0;
		lfsr_state = LFSR_SEED;
		load_vector_table();

		repeat (RESET_CYCLES) @(posedge clk);
		#2;
		rst_n_i = 1'b1;

		// Nothing enters yet, so valid_o has to stay low here
		repeat (IDLE_CYCLES) drive_operation(1'b0, FP_OP_FMUL, '0, '0, '0);

		for (int i = 0; i < VEC_COUNT; i++)
		begin
			drive_operation(vec_table[i].valid, vec_table[i].op, vec_table[i].operand_a,
				vec_table[i].operand_b, vec_table[i].expected);
		end

		// Random products follow back to back with valid held high
		for (int i = 0; i < RAND_COUNT; i++)
		begin
			random_operand(rand_a);
			random_operand(rand_b);
			drive_operation(1'b1, FP_OP_FMUL, rand_a, rand_b, fmul_model(rand_a, rand_b));
		end
		drive_operation(1'b0, FP_OP_FMUL, '0, '0, '0);

		while (pending_q.size() != 0) @(posedge clk);

		// A few quiet cycles catch any stray valid_o pulse
		repeat (LATENCY + 1) @(posedge clk);

		report_counts();
		if (value_errors + valid_errors == 0)
		begin
			$display("Simulation passed");
		end
		else
		begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// File: hw/fpmul_top.sv
// ################################################
// Top level of the floating-point multiply pipeline
// Chains preparation, multiplication and
// normalization, giving results 3 cycles after input
// ################################################

`timescale 1ns/1ns

module fpmul_top (
	input logic clk,
	input logic rst_n_i,
	input logic valid_i,
	input fpmul_pkg::fp_op_e op_i,
	input fpmul_pkg::fp_word_t operand_a_i,
	input fpmul_pkg::fp_word_t operand_b_i,
	output logic valid_o,
	output fpmul_pkg::fp_word_t result_o
);

	import fpmul_pkg::*;

	// Registered record from stage 1 into stage 2
	prep_stage_t prep;

	// Registered record from stage 2 into stage 3
	product_stage_t product;

	// Stage 1 unpacks the operands and sets up the multiply
	fpmul_operand_prep u_operand_prep (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.valid_i(valid_i),
		.op_i(op_i),
		.operand_a_i(operand_a_i),
		.operand_b_i(operand_b_i),
		.prep_o(prep)
	);

	// Stage 2 holds the wide multiplier on its own
	fpmul_significand_mult u_significand_mult (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.prep_i(prep),
		.product_o(product)
	);

	// Stage 3 normalizes and drives the outputs from its registers
	fpmul_normalize u_normalize (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.product_i(product),
		.valid_o(valid_o),
		.result_o(result_o)
	);

endmodule

// File: hw/fpmul_normalize.sv
// ################################################
// Stage 3 of the multiply pipeline
// Normalizes the product around its leading one,
// truncates to 24 bits and packs the IEEE word
// ################################################

`timescale 1ns/1ns

module fpmul_normalize (
	input logic clk,
	input logic rst_n_i,
	input fpmul_pkg::product_stage_t product_i,
	output logic valid_o,
	output fpmul_pkg::fp_word_t result_o
);

	import fpmul_pkg::*;

	// Position of the most significant set bit in the product
	logic [LEAD_WIDTH-1:0] lead_pos;

	// Left shift that brings the leading one to the top bit
	logic [LEAD_WIDTH-1:0] shift_amt;
	logic [PRODUCT_WIDTH-1:0] shifted;

	work_exp_t norm_exp;
	fp_word_t result_next;

	// Priority search where a higher set bit overrides any lower one
	always_comb
	begin
		lead_pos = '0;
		for (int i = 0; i < PRODUCT_WIDTH; i++)
		begin
			if (product_i.product[i])
			begin
				lead_pos = LEAD_WIDTH'(i);
			end
		end
	end

	assign shift_amt = LEAD_WIDTH'(PRODUCT_WIDTH - 1) - lead_pos;
	assign shifted = product_i.product << shift_amt;

	// A leading one at bit 46 leaves the incoming exponent unchanged
	assign norm_exp = product_i.exponent
		+ work_exp_t'(lead_pos)
		- work_exp_t'(PRODUCT_SHIFT);

	always_comb
	begin
		result_next = '0;
		if (!product_i.zero)
		begin
			result_next.sign = product_i.sign;

			// Range is kept normal by the caller, so only the low bits are needed
			result_next.exponent = norm_exp[FP_EXP_WIDTH-1:0];

			// The top bit is the hidden one and everything below the
			// fraction is dropped, which truncates toward zero
			result_next.fraction = shifted[PRODUCT_WIDTH-2 -: FP_SIG_WIDTH];
		end
	end

	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			valid_o <= 1'b0;
			result_o <= '0;
		end
		else
		begin
			valid_o <= product_i.valid;
			result_o <= result_next;
		end
	end

endmodule

// File: hw/fpmul_significand_mult.sv
// ################################################
// Stage 2 of the multiply pipeline
// Forms the full significand product and carries
// sign, exponent and flags along unchanged
// ################################################

`timescale 1ns/1ns

module fpmul_significand_mult (
	input logic clk,
	input logic rst_n_i,
	input fpmul_pkg::prep_stage_t prep_i,
	output fpmul_pkg::product_stage_t product_o
);

	import fpmul_pkg::*;

	// Wide unsigned product on the critical path that this stage isolates
	logic [PRODUCT_WIDTH-1:0] product;

	assign product = PRODUCT_WIDTH'(prep_i.multiplicand) * PRODUCT_WIDTH'(prep_i.multiplier);

	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			product_o <= '0;
		end
		else
		begin
			product_o.valid <= prep_i.valid;
			product_o.zero <= prep_i.zero;
			product_o.sign <= prep_i.sign;
			product_o.exponent <= prep_i.exponent;
			product_o.product <= product;
		end
	end

endmodule

// File: hw/fpmul_operand_prep.sv
// ################################################
// Stage 1 of the multiply pipeline
// Unpacks the operands, flags a zero result, sums
// the exponents and builds the multiplier inputs
// ################################################

`timescale 1ns/1ns

module fpmul_operand_prep (
	input logic clk,
	input logic rst_n_i,
	input logic valid_i,
	input fpmul_pkg::fp_op_e op_i,
	input fpmul_pkg::fp_word_t operand_a_i,
	input fpmul_pkg::fp_word_t operand_b_i,
	output fpmul_pkg::prep_stage_t prep_o
);

	import fpmul_pkg::*;

	// Operand b viewed as a two's-complement integer for ITOF
	logic [FP_WIDTH-1:0] int_b;
	logic [FP_WIDTH-1:0] int_mag;

	// Zero checks ignore the sign so that -0.0 counts as zero
	logic a_is_zero;
	logic b_is_zero;
	logic is_zero;

	prep_stage_t prep_next;

	assign int_b = operand_b_i;

	// The most negative integer maps onto 2^31, which still fits unsigned
	assign int_mag = int_b[FP_WIDTH-1] ? (~int_b + 1'b1) : int_b;

	assign a_is_zero = ({operand_a_i.exponent, operand_a_i.fraction} == '0);
	assign b_is_zero = ({operand_b_i.exponent, operand_b_i.fraction} == '0);

	// Only the integer matters for ITOF since operand a is ignored there
	assign is_zero = (op_i == FP_OP_ITOF) ? (int_b == '0) : (a_is_zero || b_is_zero);

	always_comb
	begin
		prep_next = '0;
		prep_next.valid = valid_i;
		prep_next.zero = is_zero;
		if (op_i == FP_OP_ITOF)
		begin
			// Multiply the integer magnitude by 1.0, which is the hidden one alone
			prep_next.sign = int_b[FP_WIDTH-1];
			prep_next.exponent = work_exp_t'(ITOF_EXP);
			prep_next.multiplicand = {1'b1, {FP_SIG_WIDTH{1'b0}}};
			prep_next.multiplier = int_mag;
		end
		else
		begin
			prep_next.sign = operand_a_i.sign ^ operand_b_i.sign;

			// One bias is removed so the sum stays a single biased exponent
			prep_next.exponent = work_exp_t'(operand_a_i.exponent)
				+ work_exp_t'(operand_b_i.exponent)
				- work_exp_t'(FP_BIAS);
			prep_next.multiplicand = {1'b1, operand_a_i.fraction};

			// The multiplier port is wider than a significand, so pad on top
			prep_next.multiplier = FP_WIDTH'({1'b1, operand_b_i.fraction});
		end

		// A zero multiplier makes the product zero for any multiplicand
		if (is_zero)
		begin
			prep_next.multiplier = '0;
		end
	end

	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			prep_o <= '0;
		end
		else
		begin
			prep_o <= prep_next;
		end
	end

endmodule

// File: hw/fpmul_pkg.sv
// ################################################
// Shared widths, opcodes and stage records for the
// three-stage floating-point multiply pipeline
// Every pipeline module imports this package
// ################################################

package fpmul_pkg;

	// IEEE single-precision field widths and exponent bias
	localparam int FP_EXP_WIDTH = 8;
	localparam int FP_SIG_WIDTH = 23;
	localparam int FP_WIDTH = 32;
	localparam int FP_BIAS = 127;

	// Significand with its hidden one restored
	localparam int MANT_WIDTH = FP_SIG_WIDTH + 1;

	// The multiplier is wide enough for a full 32-bit integer magnitude
	localparam int PRODUCT_WIDTH = 64;

	// Bits needed to name any position within the product
	localparam int LEAD_WIDTH = $clog2(PRODUCT_WIDTH);

	// Two 24-bit significands multiply into a value scaled by 2^46
	localparam int PRODUCT_SHIFT = 2 * FP_SIG_WIDTH;

	// An integer times 1.0 needs this exponent to satisfy the value rule
	localparam int ITOF_EXP = FP_BIAS + FP_SIG_WIDTH;

	// Signed working exponent with headroom for sums and shifts
	localparam int WORK_EXP_WIDTH = 10;

	typedef logic signed [WORK_EXP_WIDTH-1:0] work_exp_t;

	typedef enum logic {
		FP_OP_FMUL,
		FP_OP_ITOF
	} fp_op_e;

	typedef struct packed {
		logic sign;
		logic [FP_EXP_WIDTH-1:0] exponent;
		logic [FP_SIG_WIDTH-1:0] fraction;
	} fp_word_t;

	// The value carried is product * 2^(exponent - FP_BIAS - PRODUCT_SHIFT)
	typedef struct packed {
		logic valid;
		logic zero;
		logic sign;
		work_exp_t exponent;
		logic [MANT_WIDTH-1:0] multiplicand;
		logic [FP_WIDTH-1:0] multiplier;
	} prep_stage_t;

	typedef struct packed {
		logic valid;
		logic zero;
		logic sign;
		work_exp_t exponent;
		logic [PRODUCT_WIDTH-1:0] product;
	} product_stage_t;

endpackage
